// File: common/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  // Sizes
  localparam int WORD_W    = 64;  // SPI word
  localparam int DIV_W     = 24;  // Tick divisor
  localparam int USTEP_W   = 2;   // 0 full step .. 3 eighth step
  localparam int POS_W     = 5;   // 32 eighth steps per electrical cycle
  localparam int PWM_W     = 8;
  localparam int BIT_CNT_W = 7;   // Room to count past one word

  // Bit count of a well-formed frame
  localparam logic [BIT_CNT_W-1:0] FRAME_BITS = 7'd64;

  // Command headers, word bits 63:56
  localparam logic [7:0] CMD_MOVE    = 8'h01;
  localparam logic [7:0] CMD_DIVISOR = 8'h03;
  localparam logic [7:0] CMD_USTEP   = 8'h04;

  // Values after reset
  localparam logic [DIV_W-1:0]   DIV_DEFAULT   = 24'd32;
  localparam logic [USTEP_W-1:0] USTEP_DEFAULT = 2'd0;

  // One coordinated move as handed to the DDA
  typedef struct packed {
    logic               dir;
    logic [63:0]        duration;  // Ticks
    logic [63:0]        velocity;  // Unsigned phase increment
    logic signed [63:0] accel;     // Added to velocity every tick
  } move_cmd_t;

  // Word returned to the host on CIPO
  typedef struct packed {
    logic [7:0]  last_header;
    logic        busy;
    logic        pending;
    logic [1:0]  usteps;
    logic [19:0] reserved;
    logic [31:0] step_count;
  } status_t;

endpackage

`default_nettype wire

// File: motion/motion_dda.sv
`default_nettype none
`timescale 1ns/1ps

module motion_dda (
  input  wire                          CLK,
  input  wire                          rst_n,
  input  wire                          move_req,
  input  wire stepper_pkg::move_cmd_t  move_cmd,
  output logic                         move_ack,
  input  wire                          tick,
  output logic                         busy,
  output logic                         step,
  output logic                         dir,
  output logic [31:0]                  step_count
);

  logic [63:0] vel;
  logic [63:0] accel;
  logic [63:0] phase;
  logic [63:0] duration;
  logic [63:0] tick_cnt;
  logic [65:0] vel_sum;
  logic [63:0] vel_next;
  logic [64:0] phase_sum;
  logic        accept;
  logic        advance;

  assign accept  = move_req && !move_ack && !busy;
  assign advance = busy && tick && (duration != '0);

  // Signed add, anything outside 0..2^64-1 stops the motor
  assign vel_sum   = {2'b00, vel} + {{2{accel[63]}}, accel};
  assign vel_next  = (|vel_sum[65:64]) ? '0 : vel_sum[63:0];
  assign phase_sum = {1'b0, phase} + {1'b0, vel_next};

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      move_ack   <= 1'b0;
      busy       <= 1'b0;
      step       <= 1'b0;
      dir        <= 1'b0;
      step_count <= '0;
      tick_cnt   <= '0;
    end else begin
      step <= 1'b0;

      if (accept)
        move_ack <= 1'b1;
      else if (move_ack && !move_req)
        move_ack <= 1'b0;

      if (accept) begin
        busy       <= 1'b1;
        dir        <= move_cmd.dir;
        step_count <= '0;
        tick_cnt   <= '0;
      end else if (busy && duration == '0) begin
        busy <= 1'b0;  // Empty move
      end else if (advance) begin
        tick_cnt <= tick_cnt + 64'd1;
        step     <= phase_sum[64];  // Carry out issues a step
        if (phase_sum[64])
          step_count <= step_count + 32'd1;
        if (tick_cnt + 64'd1 == duration)
          busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      vel      <= move_cmd.velocity;
      accel    <= move_cmd.accel;
      duration <= move_cmd.duration;
      phase    <= '0;
    end else if (advance) begin
      vel   <= vel_next;
      phase <= phase_sum[63:0];
    end
  end

endmodule

`default_nettype wire

// File: rtl/cmd_parser.sv
`default_nettype none
`timescale 1ns/1ps

module cmd_parser (
  input  wire                                 CLK,
  input  wire                                 rst_n,
  input  wire                                 word_req,
  input  wire [stepper_pkg::WORD_W-1:0]       word_data,
  output logic                                word_ack,
  output logic                                move_req,
  output stepper_pkg::move_cmd_t              move_cmd,
  input  wire                                 move_ack,
  output logic [stepper_pkg::DIV_W-1:0]       divisor,
  output logic [stepper_pkg::USTEP_W-1:0]     usteps,
  output logic [7:0]                          last_header,
  output logic                                pending
);

  typedef enum logic [2:0] {IDLE, MOVE_DUR, MOVE_VEL, MOVE_ACC, HANDOFF} state_t;

  state_t     state;
  logic [7:0] header;
  logic       take;

  assign header = word_data[stepper_pkg::WORD_W-1 -: 8];

  // No new words while a move waits for the DDA
  assign take    = word_req && !word_ack && (state != HANDOFF);
  assign pending = (state == HANDOFF);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      word_ack    <= 1'b0;
      move_req    <= 1'b0;
      divisor     <= stepper_pkg::DIV_DEFAULT;
      usteps      <= stepper_pkg::USTEP_DEFAULT;
      last_header <= 8'h00;
    end else begin
      if (take)
        word_ack <= 1'b1;
      else if (word_ack && !word_req)
        word_ack <= 1'b0;

      case (state)
        IDLE: begin
          if (take) begin
            case (header)
              stepper_pkg::CMD_MOVE: state <= MOVE_DUR;
              stepper_pkg::CMD_DIVISOR: begin
                // Zero would stall the timer
                divisor <= (word_data[stepper_pkg::DIV_W-1:0] == '0) ?
                           {{(stepper_pkg::DIV_W-1){1'b0}}, 1'b1} :
                           word_data[stepper_pkg::DIV_W-1:0];
                last_header <= header;
              end
              stepper_pkg::CMD_USTEP: begin
                usteps <= (|word_data[55:stepper_pkg::USTEP_W]) ? '1 :
                          word_data[stepper_pkg::USTEP_W-1:0];  // Clamp to eighth step
                last_header <= header;
              end
              default: ;  // Unknown header, acked and ignored
            endcase
          end
        end
        MOVE_DUR: if (take) state <= MOVE_VEL;
        MOVE_VEL: if (take) state <= MOVE_ACC;
        MOVE_ACC: if (take) state <= HANDOFF;
        HANDOFF: begin
          if (move_req && move_ack) begin
            move_req    <= 1'b0;
            last_header <= stepper_pkg::CMD_MOVE;
            state       <= IDLE;
          end else if (!move_req && !move_ack) begin
            move_req <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Move fields filled word by word
  always_ff @(posedge CLK) begin
    if (take) begin
      case (state)
        IDLE:     if (header == stepper_pkg::CMD_MOVE) move_cmd.dir <= word_data[0];
        MOVE_DUR: move_cmd.duration <= word_data;
        MOVE_VEL: move_cmd.velocity <= word_data;
        MOVE_ACC: move_cmd.accel    <= word_data;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/hbridge_driver.sv
`default_nettype none
`timescale 1ns/1ps

module hbridge_driver (
  input  wire                              CLK,
  input  wire                              rst_n,
  input  wire                              step,
  input  wire                              dir,
  input  wire [stepper_pkg::USTEP_W-1:0]   usteps,
  output logic                             phase_a1,
  output logic                             phase_a2,
  output logic                             phase_b1,
  output logic                             phase_b2,
  output logic                             pwm_a,
  output logic                             pwm_b
);

  logic [stepper_pkg::POS_W-1:0] pos;
  logic [stepper_pkg::POS_W-1:0] pos_b;
  logic [stepper_pkg::POS_W-1:0] delta;
  logic                          enabled;
  logic [stepper_pkg::PWM_W-1:0] pwm_cnt;
  logic [stepper_pkg::PWM_W-1:0] mag_a;
  logic [stepper_pkg::PWM_W-1:0] mag_b;

  // Quarter sine over 8 eighth steps, mirrored in the second quarter
  function automatic logic [stepper_pkg::PWM_W-1:0] sine_mag(
      input logic [stepper_pkg::POS_W-1:0] p);
    logic [stepper_pkg::POS_W-2:0] q;
    q = p[stepper_pkg::POS_W-2] ? (4'd8 - {1'b0, p[stepper_pkg::POS_W-3:0]}) :
                                  {1'b0, p[stepper_pkg::POS_W-3:0]};
    case (q)
      4'd0: sine_mag = 8'd0;
      4'd1: sine_mag = 8'd50;
      4'd2: sine_mag = 8'd98;
      4'd3: sine_mag = 8'd142;
      4'd4: sine_mag = 8'd180;
      4'd5: sine_mag = 8'd212;
      4'd6: sine_mag = 8'd236;
      4'd7: sine_mag = 8'd250;
      default: sine_mag = 8'd255;
    endcase
  endfunction

  assign delta = {{(stepper_pkg::POS_W-1){1'b0}}, 1'b1} << (2'd3 - usteps);
  assign pos_b = pos + 5'd8;  // Coil B leads by a quarter cycle
  assign mag_a = sine_mag(pos);
  assign mag_b = sine_mag(pos_b);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pos     <= '0;
      enabled <= 1'b0;
    end else if (step) begin
      pos     <= dir ? pos + delta : pos - delta;  // Wraps mod 32
      enabled <= 1'b1;
    end
  end

  assign phase_a1 = enabled & ~pos[stepper_pkg::POS_W-1];
  assign phase_a2 = enabled & pos[stepper_pkg::POS_W-1];
  assign phase_b1 = enabled & ~pos_b[stepper_pkg::POS_W-1];
  assign phase_b2 = enabled & pos_b[stepper_pkg::POS_W-1];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pwm_cnt <= '0;
      pwm_a   <= 1'b0;
      pwm_b   <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;  // Free running
      pwm_a   <= enabled && (pwm_cnt < mag_a);
      pwm_b   <= enabled && (pwm_cnt < mag_b);
    end
  end

endmodule

`default_nettype wire

// File: rtl/stepper_ctrl_top.sv
`default_nettype none
`timescale 1ns/1ps

module stepper_ctrl_top (
  input  wire  CLK,
  input  wire  rst_n,
  input  wire  sck,
  input  wire  ssel,
  input  wire  copi,
  output logic cipo,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic pwm_a,
  output logic pwm_b,
  output logic led
);

  stepper_pkg::status_t              status;
  logic                              word_req;
  logic                              word_ack;
  logic [stepper_pkg::WORD_W-1:0]    word_data;
  logic                              move_req;
  logic                              move_ack;
  stepper_pkg::move_cmd_t            move_cmd;
  logic [stepper_pkg::DIV_W-1:0]     divisor;
  logic [stepper_pkg::USTEP_W-1:0]   usteps;
  logic [7:0]                        last_header;
  logic                              pending;
  logic                              busy;
  logic                              tick;
  logic                              step;
  logic                              dir;
  logic [31:0]                       step_count;

  assign status = '{last_header: last_header, busy: busy, pending: pending,
                    usteps: usteps, reserved: '0, step_count: step_count};
  assign led = busy;

  spi_word_rx rx_inst (
    .CLK(CLK), .rst_n(rst_n), .sck(sck), .ssel(ssel), .copi(copi), .cipo(cipo),
    .status(status), .word_req(word_req), .word_data(word_data), .word_ack(word_ack)
  );

  cmd_parser parser_inst (
    .CLK(CLK), .rst_n(rst_n), .word_req(word_req), .word_data(word_data),
    .word_ack(word_ack), .move_req(move_req), .move_cmd(move_cmd), .move_ack(move_ack),
    .divisor(divisor), .usteps(usteps), .last_header(last_header), .pending(pending)
  );

  tick_timer timer_inst (
    .CLK(CLK), .rst_n(rst_n), .run(busy), .divisor(divisor), .tick(tick)
  );

  motion_dda dda_inst (
    .CLK(CLK), .rst_n(rst_n), .move_req(move_req), .move_cmd(move_cmd),
    .move_ack(move_ack), .tick(tick), .busy(busy), .step(step), .dir(dir),
    .step_count(step_count)
  );

  hbridge_driver driver_inst (
    .CLK(CLK), .rst_n(rst_n), .step(step), .dir(dir), .usteps(usteps),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1),
    .phase_b2(phase_b2), .pwm_a(pwm_a), .pwm_b(pwm_b)
  );

endmodule

`default_nettype wire

// File: rtl/tick_timer.sv
`default_nettype none
`timescale 1ns/1ps

module tick_timer (
  input  wire                            CLK,
  input  wire                            rst_n,
  input  wire                            run,
  input  wire [stepper_pkg::DIV_W-1:0]   divisor,
  output logic                           tick
);

  logic [stepper_pkg::DIV_W-1:0] cnt;
  logic [stepper_pkg::DIV_W-1:0] cnt_next;

  assign cnt_next = cnt + 1'b1;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (!run) begin
      cnt  <= '0;  // Fresh period for each move
      tick <= 1'b0;
    end else if (cnt_next >= divisor) begin
      cnt  <= '0;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt_next;
      tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the stepper controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --timing -Wno-fatal --top-module stepper_tb \
  -f sources.f -o stepper_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/stepper_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Finished with errors" "$SIM_LOG"; then
  exit 1
fi
exit 0

// File: sources.f
+incdir+testbench
common/stepper_pkg.sv
spi/spi_word_rx.sv
rtl/cmd_parser.sv
rtl/tick_timer.sv
motion/motion_dda.sv
rtl/hbridge_driver.sv
rtl/stepper_ctrl_top.sv
testbench/stepper_tb.sv

// File: spi/spi_word_rx.sv
`default_nettype none
`timescale 1ns/1ps

module spi_word_rx (
  input  wire                              CLK,
  input  wire                              rst_n,
  input  wire                              sck,
  input  wire                              ssel,
  input  wire                              copi,
  output logic                             cipo,
  input  wire stepper_pkg::status_t        status,
  output logic                             word_req,
  output logic [stepper_pkg::WORD_W-1:0]   word_data,
  input  wire                              word_ack
);

  logic [2:0] sck_sync;
  logic [2:0] ssel_sync;
  logic [1:0] copi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       ssel_rise;
  logic       ssel_fall;
  logic       active;
  logic [stepper_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [stepper_pkg::WORD_W-1:0]    rx_shift;
  logic [stepper_pkg::WORD_W-1:0]    tx_shift;
  logic       frame_end;
  logic       frame_ok;

  // Two flops into CLK, third flop for edges
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync  <= 3'b000;
      ssel_sync <= 3'b111;  // Deselected while idle
      copi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      ssel_sync <= {ssel_sync[1:0], ssel};
      copi_sync <= {copi_sync[0], copi};
    end
  end

  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  assign ssel_rise = ssel_sync[1] & ~ssel_sync[2];
  assign ssel_fall = ~ssel_sync[1] & ssel_sync[2];
  assign active    = ~ssel_sync[1];

  // Bit counter saturates one past a full word
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (ssel_fall) begin
      bit_cnt <= '0;
    end else if (active && sck_rise && bit_cnt <= stepper_pkg::FRAME_BITS) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (active && sck_rise)
      rx_shift <= {rx_shift[stepper_pkg::WORD_W-2:0], copi_sync[1]};  // MSB first
  end

  // Status snapshot at frame start, next bit on each SCK fall
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n)
      tx_shift <= '0;
    else if (ssel_fall)
      tx_shift <= status;
    else if (active && sck_fall)
      tx_shift <= {tx_shift[stepper_pkg::WORD_W-2:0], 1'b0};
  end

  assign cipo = tx_shift[stepper_pkg::WORD_W-1];

  // End of frame -> length check -> offer
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      frame_end <= 1'b0;
      frame_ok  <= 1'b0;
      word_req  <= 1'b0;
    end else begin
      frame_end <= ssel_rise;
      frame_ok  <= frame_end && (bit_cnt == stepper_pkg::FRAME_BITS);
      if (frame_ok && !word_req && !word_ack)
        word_req <= 1'b1;  // Dropped if handshake still open
      else if (word_req && word_ack)
        word_req <= 1'b0;
    end
  end

  // Held stable while word_req is high
  always_ff @(posedge CLK) begin
    if (frame_ok && !word_req && !word_ack)
      word_data <= rx_shift;
  end

endmodule

`default_nettype wire

// File: testbench/spi_host_tasks.svh
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// SPI mode 0 host, MSB first, SCK half period of SCK_HALF clocks
// The idle gap before SSEL falls lets the last word clear its handshake
task automatic spi_frame(input logic [63:0] tx, input int nbits, output logic [63:0] rx);
  int i;
  rx = '0;
  repeat (FRAME_GAP) @(posedge CLK);
  ssel <= 1'b0;
  for (i = 0; i < nbits; i++) begin
    copi <= tx[63 - i];  // Host changes COPI with SCK low
    repeat (SCK_HALF - 1) @(posedge CLK);
    @(negedge CLK);
    rx = {rx[62:0], cipo};  // CIPO settled since the last SCK fall
    @(posedge CLK);
    sck <= 1'b1;
    repeat (SCK_HALF) @(posedge CLK);
    sck <= 1'b0;
  end
  repeat (SCK_HALF) @(posedge CLK);
  ssel <= 1'b1;
  copi <= 1'b0;
endtask

task automatic send_word(input logic [63:0] word);
  logic [63:0] unused_rx;
  spi_frame(word, 64, unused_rx);
endtask

// Header 0x00 is ignored by the parser, so this frame only reads status
task automatic poll_status(output logic [63:0] rx);
  spi_frame(POLL_WORD, 64, rx);
endtask

task automatic send_move(input logic d, input logic [63:0] duration,
                         input logic [63:0] velocity, input logic [63:0] accel);
  send_word({stepper_pkg::CMD_MOVE, 55'd0, d});
  send_word(duration);
  send_word(velocity);
  send_word(accel);
endtask

`endif

// File: testbench/stepper_tb.sv
`default_nettype none
`timescale 1ns/1ps

module stepper_tb;

  localparam int HALF_CLK  = 10;  // 20 ns period
  localparam int SCK_HALF  = 4;
  localparam int FRAME_GAP = 12;
  // About 55 frames of ~530 CLK plus ~9000 CLK of moves, with ample margin
  localparam int MAX_CYCLES = 200000;
  localparam logic [31:0] RAND_SEED = 32'he8af_71b9;
  localparam logic [63:0] POLL_WORD = 64'h0;

  logic CLK;
  logic rst_n;
  logic sck;
  logic ssel;
  logic copi;
  logic cipo;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic pwm_a;
  logic pwm_b;
  logic led;

  int cycles = 0;
  int errors = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  // Reference model of the host-visible state
  logic [7:0]  m_last_header;
  logic [1:0]  m_usteps;
  logic [23:0] m_divisor;
  logic [4:0]  m_pos;
  logic        m_enabled;

  stepper_ctrl_top stepper_ctrl_top_inst (
    .CLK(CLK), .rst_n(rst_n), .sck(sck), .ssel(ssel), .copi(copi), .cipo(cipo),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1),
    .phase_b2(phase_b2), .pwm_a(pwm_a), .pwm_b(pwm_b), .led(led)
  );

  `include "spi_host_tasks.svh"

  initial begin
    CLK = 1'b0;
    forever #(HALF_CLK) CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: FAILED with %0d errors", name, test_errors);
      tests_failed++;
    end
    errors += test_errors;
    test_errors = 0;
    tests_run++;
  endtask

  function automatic logic [63:0] expected_status(input logic [31:0] steps);
    stepper_pkg::status_t s;
    s = '0;
    s.last_header = m_last_header;
    s.usteps      = m_usteps;
    s.step_count  = steps;
    return s;
  endfunction

  // Second-order DDA in 128 bits, velocity clamps to 0 outside 0..2^64-1
  function automatic logic [31:0] predict_steps(input logic [63:0] vel0,
      input logic [63:0] acc, input int dur);
    logic [127:0] v;
    logic [127:0] ph;
    logic [31:0]  n;
    int           i;
    v  = {64'd0, vel0};
    ph = '0;
    n  = '0;
    for (i = 0; i < dur; i++) begin
      v = v + {{64{acc[63]}}, acc};
      if (|v[127:64])
        v = '0;
      ph = ph + v;
      if (ph[64]) begin
        n = n + 32'd1;
        ph[64] = 1'b0;
      end
    end
    return n;
  endfunction

  task automatic apply_model_move(input logic d, input logic [31:0] steps);
    logic [4:0] delta;
    int         i;
    delta = 5'd1 << (2'd3 - m_usteps);
    for (i = 0; i < int'(steps); i++)
      m_pos = d ? m_pos + delta : m_pos - delta;
    if (steps != 0)
      m_enabled = 1'b1;
    m_last_header = stepper_pkg::CMD_MOVE;
  endtask

  task automatic check_phases();
    logic [4:0] pos_b;
    pos_b = m_pos + 5'd8;  // Coil B a quarter cycle ahead
    @(negedge CLK);
    check_value("phase_a1", 64'(phase_a1), 64'(m_enabled & ~m_pos[4]));
    check_value("phase_a2", 64'(phase_a2), 64'(m_enabled & m_pos[4]));
    check_value("phase_b1", 64'(phase_b1), 64'(m_enabled & ~pos_b[4]));
    check_value("phase_b2", 64'(phase_b2), 64'(m_enabled & pos_b[4]));
  endtask

  task automatic set_usteps(input logic [55:0] val);
    send_word({stepper_pkg::CMD_USTEP, val});
    m_usteps = (val > 56'd3) ? 2'd3 : val[1:0];
    m_last_header = stepper_pkg::CMD_USTEP;
  endtask

  task automatic set_divisor(input logic [23:0] val);
    send_word({stepper_pkg::CMD_DIVISOR, 32'd0, val});
    m_divisor = (val == 24'd0) ? 24'd1 : val;
    m_last_header = stepper_pkg::CMD_DIVISOR;
  endtask

  task automatic wait_led(input logic level, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (led !== level && n < limit);
    check_true(led === level, $sformatf("led did not go to %0b within %0d cycles", level, limit));
  endtask

  // led dips for one cycle between back-to-back moves, so wait for a quiet stretch
  task automatic wait_idle(input int limit);
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 4 && n < limit) begin
      @(negedge CLK);
      n++;
      quiet = led ? 0 : quiet + 1;
    end
    check_true(quiet >= 4, $sformatf("move still running after %0d cycles", limit));
  endtask

  task automatic test_reset_state();
    logic [63:0] rx;
    @(negedge CLK);
    check_value("{phase_a1,phase_a2,phase_b1,phase_b2,pwm_a,pwm_b,led}",
                {57'd0, phase_a1, phase_a2, phase_b1, phase_b2, pwm_a, pwm_b, led}, 64'd0);
    poll_status(rx);
    check_value("status", rx, expected_status(32'd0));
    finish_test("test 1 reset state");
  endtask

  task automatic test_config();
    logic [63:0] rx;
    set_usteps(56'd2);
    poll_status(rx);
    check_value("status", rx, expected_status(32'd0));
    set_usteps(56'd7);  // Clamped to eighth step
    poll_status(rx);
    check_value("status", rx, expected_status(32'd0));
    set_usteps(56'd4);  // Low bits alone would give full step
    poll_status(rx);
    check_value("status", rx, expected_status(32'd0));
    set_divisor(24'd0);
    poll_status(rx);
    check_value("status", rx, expected_status(32'd0));
    finish_test("test 2 divisor and microstep");
  endtask

  task automatic test_constant_move();
    logic [63:0] rx;
    logic [63:0] vel;
    logic [31:0] steps;
    int          n;
    int          coils_on;
    int          busy_len;
    vel   = 64'h4000_0000_0000_0000;
    steps = predict_steps(vel, 64'd0, 16);
    send_move(1'b1, 64'd16, vel, 64'd0);
    wait_led(1'b1, 64);
    n        = 0;
    coils_on = 0;
    busy_len = 1;  // First cycle with led high already seen
    while (led === 1'b1 && n < 1000) begin
      @(negedge CLK);
      n++;
      if (coils_on == 0 && (phase_a1 | phase_a2))
        coils_on = n;
      if (led === 1'b1)
        busy_len++;
    end
    // Coils switch on one CLK after the first step
    check_true(coils_on > int'(m_divisor),
               $sformatf("first step %0d cycles after busy, before the divisor", coils_on - 1));
    // Sixteen tick periods, then one CLK to drop busy
    check_value("busy cycles", 64'(busy_len), 64'(16 * int'(m_divisor) + 1));
    wait_idle(64);
    apply_model_move(1'b1, steps);
    poll_status(rx);
    check_value("status", rx, expected_status(steps));
    check_phases();
    finish_test("test 3 constant velocity move");
  endtask

  task automatic test_random_moves();
    logic [63:0] rx;
    logic [63:0] vel;
    logic [63:0] acc;
    logic [31:0] steps;
    logic        d;
    int          dur;
    int          k;
    set_divisor(24'($urandom_range(1, 4)));
    for (k = 0; k < 4; k++) begin
      set_usteps(56'($urandom_range(0, 3)));
      d   = 1'($urandom_range(0, 1));
      dur = int'($urandom_range(0, 40));
      vel = {$urandom, $urandom};
      acc = {$urandom, $urandom};
      acc = $signed(acc) >>> $urandom_range(1, 12);  // Mix of clamped and smooth ramps
      steps = predict_steps(vel, acc, dur);
      send_move(d, 64'(dur), vel, acc);
      wait_led(1'b1, 64);
      wait_idle((dur + 2) * int'(m_divisor) + 16);
      apply_model_move(d, steps);
      poll_status(rx);
      check_value("status", rx, expected_status(steps));
      check_phases();
    end
    finish_test("test 4 randomised moves");
  endtask

  task automatic test_backpressure();
    logic [63:0] rx;
    logic [63:0] prev;
    logic [63:0] short_rx;
    logic [31:0] steps_a;
    logic [31:0] steps_b;
    stepper_pkg::status_t st;
    set_divisor(24'd200);  // First move outlasts five frames
    steps_a = predict_steps(64'h6000_0000_0000_0000, 64'd0, 30);
    steps_b = predict_steps(64'h9000_0000_0000_0000, 64'h0100_0000_0000_0000, 10);
    send_move(1'b1, 64'd30, 64'h6000_0000_0000_0000, 64'd0);
    send_move(1'b0, 64'd10, 64'h9000_0000_0000_0000, 64'h0100_0000_0000_0000);
    poll_status(rx);
    st = rx;
    check_value("status.busy", 64'(st.busy), 64'd1);
    check_value("status.pending", 64'(st.pending), 64'd1);
    wait_idle(45 * 200);
    apply_model_move(1'b1, steps_a);
    apply_model_move(1'b0, steps_b);
    poll_status(prev);
    check_value("status", prev, expected_status(steps_b));
    check_phases();
    // The 63 bits that go out still line up as a microstep command
    spi_frame({stepper_pkg::CMD_USTEP, 56'd1} << 1, 63, short_rx);
    poll_status(rx);
    check_value("status after 63-bit frame", rx, prev);
    finish_test("test 5 back-pressure and short frame");
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    rst_n = 1'b0;
    sck   = 1'b0;
    ssel  = 1'b1;
    copi  = 1'b0;
    m_last_header = 8'h00;
    m_usteps      = stepper_pkg::USTEP_DEFAULT;
    m_divisor     = stepper_pkg::DIV_DEFAULT;
    m_pos         = 5'd0;
    m_enabled     = 1'b0;
    repeat (4) @(posedge CLK);
    rst_n <= 1'b1;

    test_reset_state();
    test_config();
    test_constant_move();
    test_random_moves();
    test_backpressure();

    $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
